// ==== hw/banked_mem_cfg.svh ====
`ifndef BANKED_MEM_CFG_SVH
`define BANKED_MEM_CFG_SVH

// Data word width in bits.
`define MEM_WIDTH 32

// Bank index sits in the low address bits.
`define MEM_BANK_BITS 2
`define MEM_NUM_BANKS 4

// Row index sits in the high address bits.
`define MEM_ROW_BITS 6
`define MEM_ADDR_BITS 8

// Cycles from bank read strobe to bank read data.
`define MEM_SRAM_DELAY 2

`endif

// ==== hw/mem_addr_pkg.sv ====
`include "banked_mem_cfg.svh"

package mem_addr_pkg;

  // Logical address as seen on the external ports.
  typedef logic [`MEM_ADDR_BITS-1:0] log_addr_t;

  typedef logic [`MEM_BANK_BITS-1:0] bank_idx_t;
  typedef logic [`MEM_ROW_BITS-1:0]  row_idx_t;

  // Physical address, bank above row.
  typedef logic [`MEM_ADDR_BITS-1:0] phys_addr_t;

  // One strobe bit per bank.
  typedef logic [`MEM_NUM_BANKS-1:0] bank_vec_t;

endpackage

// ==== hw/mem_data_pkg.sv ====
`include "banked_mem_cfg.svh"

package mem_data_pkg;

  typedef logic [`MEM_WIDTH-1:0] mem_data_t;
  typedef logic [`MEM_WIDTH-1:0] mem_mask_t;

  // Read data of all banks, bank 0 in the low word.
  typedef logic [`MEM_NUM_BANKS-1:0][`MEM_WIDTH-1:0] bank_data_t;

  // Holding register state.
  typedef enum logic {
    held_empty,
    held_valid
  } defer_state_t;

endpackage

// ==== hw/write_defer_ctrl.sv ====
`timescale 1ns/1ps
`include "banked_mem_cfg.svh"

module write_defer_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    write,
  input  mem_addr_pkg::log_addr_t wr_adr,
  input  mem_data_pkg::mem_mask_t bw,
  input  mem_data_pkg::mem_data_t din,
  input  logic                    read,
  input  mem_addr_pkg::log_addr_t rd_adr,
  output mem_addr_pkg::bank_vec_t mem_write,
  output mem_addr_pkg::row_idx_t  mem_wr_row,
  output mem_data_pkg::mem_mask_t mem_bw,
  output mem_data_pkg::mem_data_t mem_din,
  output mem_addr_pkg::bank_vec_t mem_read,
  output mem_addr_pkg::row_idx_t  mem_rd_row,
  output logic                    rq_vld,
  output mem_addr_pkg::bank_idx_t rq_bank,
  output mem_addr_pkg::row_idx_t  rq_row,
  output logic                    rq_fwd,
  output mem_data_pkg::mem_mask_t rq_msk,
  output mem_data_pkg::mem_data_t rq_dat
);
  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  bank_idx_t    wr_bank;
  row_idx_t     wr_row;
  bank_idx_t    rd_bank;
  row_idx_t     rd_row;

  defer_state_t state;
  bank_idx_t    held_bank;
  row_idx_t     held_row;
  mem_mask_t    held_msk;
  mem_data_t    held_dat;

  logic         held_vld;
  logic         wr_hit;
  logic         rd_hit;
  logic         cflt;
  logic         idle;
  logic         use_held;
  logic         bank_wr;
  mem_mask_t    merge_msk;
  mem_data_t    merge_base;
  mem_data_t    merge_dat;

  // ============================================================
  // Address split and hit detection
  // ============================================================
  assign wr_bank = wr_adr[`MEM_BANK_BITS-1:0];
  assign wr_row  = wr_adr[`MEM_ADDR_BITS-1:`MEM_BANK_BITS];
  assign rd_bank = rd_adr[`MEM_BANK_BITS-1:0];
  assign rd_row  = rd_adr[`MEM_ADDR_BITS-1:`MEM_BANK_BITS];

  assign held_vld = (state == held_valid);
  assign wr_hit   = held_vld && (wr_bank == held_bank) && (wr_row == held_row);
  assign rd_hit   = held_vld && (rd_bank == held_bank) && (rd_row == held_row);
  assign cflt     = write && read && (wr_adr == rd_adr);
  assign idle     = !write && !read;

  // ============================================================
  // Bank strobes
  // ============================================================
  // Held contents go out on an idle cycle or when a new collision evicts them.
  assign use_held = cflt || idle;
  assign bank_wr  = idle ? held_vld :
                    cflt ? (held_vld && !wr_hit) :
                           (write && !wr_hit);

  assign mem_write  = bank_wr ? (bank_vec_t'(1) << (use_held ? held_bank : wr_bank)) : '0;
  assign mem_wr_row = use_held ? held_row : wr_row;
  assign mem_bw     = use_held ? held_msk : bw;
  assign mem_din    = use_held ? held_dat : din;

  assign mem_read   = read ? (bank_vec_t'(1) << rd_bank) : '0;
  assign mem_rd_row = rd_row;

  // Forwarding info uses the register contents before this cycle's update.
  assign rq_vld  = read;
  assign rq_bank = rd_bank;
  assign rq_row  = rd_row;
  assign rq_fwd  = read && rd_hit;
  assign rq_msk  = held_msk;
  assign rq_dat  = held_dat;

  // ============================================================
  // Holding register
  // ============================================================
  assign merge_base = wr_hit ? held_dat : din;
  assign merge_dat  = (merge_base & ~bw) | (din & bw);
  assign merge_msk  = (wr_hit ? held_msk : '0) | bw;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= held_empty;
    end else begin
      case (state)
        held_empty: if (cflt) state <= held_valid;
        held_valid: if (idle) state <= held_empty;
        default:    state <= held_empty;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cflt || (write && wr_hit)) begin
      held_bank <= wr_bank;
      held_row  <= wr_row;
      held_msk  <= merge_msk;
      held_dat  <= merge_dat;
    end
  end

  a_strobe_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(mem_write) && $onehot0(mem_read)
  );

  // A bank never sees a write and a read of one row together.
  a_no_row_clash: assert property (
    @(posedge clk) disable iff (rst)
    !((|(mem_write & mem_read)) && (mem_wr_row == mem_rd_row))
  );

endmodule

// ==== hw/bank_sram.sv ====
`timescale 1ns/1ps
`include "banked_mem_cfg.svh"

module bank_sram (
  input  logic                    clk,
  input  logic                    wr_en,
  input  mem_addr_pkg::row_idx_t  wr_row,
  input  mem_data_pkg::mem_mask_t wr_bw,
  input  mem_data_pkg::mem_data_t wr_din,
  input  logic                    rd_en,
  input  mem_addr_pkg::row_idx_t  rd_row,
  output mem_data_pkg::mem_data_t rd_dout
);
  import mem_data_pkg::*;

  localparam int ROWS = 1 << `MEM_ROW_BITS;
  localparam int DLY  = `MEM_SRAM_DELAY;

  mem_data_t mem [ROWS];
  mem_data_t rd_pipe [DLY];

  // Bit-masked write.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= (mem[wr_row] & ~wr_bw) | (wr_din & wr_bw);
    end
  end

  // Read sees the row as it was before this cycle's write.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i < DLY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_dout = rd_pipe[DLY-1];

endmodule

// ==== hw/read_return.sv ====
`timescale 1ns/1ps
`include "banked_mem_cfg.svh"

module read_return (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rq_vld,
  input  mem_addr_pkg::bank_idx_t  rq_bank,
  input  mem_addr_pkg::row_idx_t   rq_row,
  input  logic                     rq_fwd,
  input  mem_data_pkg::mem_mask_t  rq_msk,
  input  mem_data_pkg::mem_data_t  rq_dat,
  input  mem_data_pkg::bank_data_t mem_rd_dout,
  output logic                     rd_vld,
  output mem_data_pkg::mem_data_t  rd_dout,
  output logic                     rd_fwrd,
  output mem_addr_pkg::phys_addr_t rd_padr
);
  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  localparam int DLY = `MEM_SRAM_DELAY;

  logic      vld_q  [DLY];
  logic      fwd_q  [DLY];
  bank_idx_t bank_q [DLY];
  row_idx_t  row_q  [DLY];
  mem_mask_t msk_q  [DLY];
  mem_data_t dat_q  [DLY];

  mem_data_t bank_word;

  // ============================================================
  // Tag pipeline, aligned with the bank read latency
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DLY; i++) begin
        vld_q[i] <= 1'b0;
        fwd_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= rq_vld;
      fwd_q[0] <= rq_fwd;
      for (int i = 1; i < DLY; i++) begin
        vld_q[i] <= vld_q[i-1];
        fwd_q[i] <= fwd_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank_q[0] <= rq_bank;
    row_q[0]  <= rq_row;
    msk_q[0]  <= rq_msk;
    dat_q[0]  <= rq_dat;
    for (int i = 1; i < DLY; i++) begin
      bank_q[i] <= bank_q[i-1];
      row_q[i]  <= row_q[i-1];
      msk_q[i]  <= msk_q[i-1];
      dat_q[i]  <= dat_q[i-1];
    end
  end

  // ============================================================
  // Bank select and forwarding merge
  // ============================================================
  assign bank_word = mem_rd_dout[bank_q[DLY-1]];

  assign rd_vld  = vld_q[DLY-1];
  assign rd_fwrd = fwd_q[DLY-1];
  assign rd_dout = rd_fwrd ? ((dat_q[DLY-1] & msk_q[DLY-1]) | (bank_word & ~msk_q[DLY-1])) :
                             bank_word;
  assign rd_padr = phys_addr_t'({bank_q[DLY-1], row_q[DLY-1]});

  // Forwarding is only flagged on reads, checked at the far end of the pipe.
  a_fwrd_has_vld: assert property (
    @(posedge clk) disable iff (rst)
    rd_fwrd |-> rd_vld
  );

endmodule

// ==== hw/banked_mem_top.sv ====
`timescale 1ns/1ps
`include "banked_mem_cfg.svh"

module banked_mem_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     write,
  input  mem_addr_pkg::log_addr_t  wr_adr,
  input  mem_data_pkg::mem_mask_t  bw,
  input  mem_data_pkg::mem_data_t  din,
  input  logic                     read,
  input  mem_addr_pkg::log_addr_t  rd_adr,
  output logic                     rd_vld,
  output mem_data_pkg::mem_data_t  rd_dout,
  output logic                     rd_fwrd,
  output mem_addr_pkg::phys_addr_t rd_padr
);
  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  bank_vec_t  mem_write;
  bank_vec_t  mem_read;
  row_idx_t   mem_wr_row;
  row_idx_t   mem_rd_row;
  mem_mask_t  mem_bw;
  mem_data_t  mem_din;
  bank_data_t mem_rd_dout;

  logic       rq_vld;
  bank_idx_t  rq_bank;
  row_idx_t   rq_row;
  logic       rq_fwd;
  mem_mask_t  rq_msk;
  mem_data_t  rq_dat;

  write_defer_ctrl ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .write      (write),
    .wr_adr     (wr_adr),
    .bw         (bw),
    .din        (din),
    .read       (read),
    .rd_adr     (rd_adr),
    .mem_write  (mem_write),
    .mem_wr_row (mem_wr_row),
    .mem_bw     (mem_bw),
    .mem_din    (mem_din),
    .mem_read   (mem_read),
    .mem_rd_row (mem_rd_row),
    .rq_vld     (rq_vld),
    .rq_bank    (rq_bank),
    .rq_row     (rq_row),
    .rq_fwd     (rq_fwd),
    .rq_msk     (rq_msk),
    .rq_dat     (rq_dat)
  );

  // One SRAM per bank, sharing row, mask and data.
  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    bank_sram bank_i (
      .clk     (clk),
      .wr_en   (mem_write[b]),
      .wr_row  (mem_wr_row),
      .wr_bw   (mem_bw),
      .wr_din  (mem_din),
      .rd_en   (mem_read[b]),
      .rd_row  (mem_rd_row),
      .rd_dout (mem_rd_dout[b])
    );
  end

  read_return ret_i (
    .clk         (clk),
    .rst         (rst),
    .rq_vld      (rq_vld),
    .rq_bank     (rq_bank),
    .rq_row      (rq_row),
    .rq_fwd      (rq_fwd),
    .rq_msk      (rq_msk),
    .rq_dat      (rq_dat),
    .mem_rd_dout (mem_rd_dout),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .rd_fwrd     (rd_fwrd),
    .rd_padr     (rd_padr)
  );

endmodule

// ==== verif/banked_mem_tb.sv ====
`timescale 1ns/1ps
`include "banked_mem_cfg.svh"

module banked_mem_tb;
  import mem_addr_pkg::*;
  import mem_data_pkg::*;

  localparam int DLY         = `MEM_SRAM_DELAY;
  localparam int NUM_ROWS    = 26;
  localparam int RAND_CYCLES = 300;
  localparam int DRAIN_LIMIT = 50;

  typedef struct packed {
    logic      write;
    log_addr_t wr_adr;
    mem_mask_t bw;
    mem_data_t din;
    logic      read;
    log_addr_t rd_adr;
    mem_data_t exp_dout;
    logic      exp_fwd;
  } stim_t;

  typedef struct packed {
    mem_data_t  dout;
    logic       fwd;
    phys_addr_t padr;
    int         due;
  } exp_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       write;
  log_addr_t  wr_adr;
  mem_mask_t  bw;
  mem_data_t  din;
  logic       read;
  log_addr_t  rd_adr;
  logic       rd_vld;
  mem_data_t  rd_dout;
  logic       rd_fwrd;
  phys_addr_t rd_padr;

  int          cyc = 0;
  int          val_errs = 0;
  int          proto_errs = 0;
  int          reads_seen = 0;
  logic [31:0] lfsr = 32'h22f1_1d2d;
  exp_t        exp_q [$];

  // Reference model: bank contents by logical address plus the holding register.
  mem_data_t   model_mem [1 << `MEM_ADDR_BITS];
  logic        held_on = 1'b0;
  log_addr_t   held_adr;
  mem_mask_t   held_msk;
  mem_data_t   held_dat;

  // Columns: write, wr_adr, bw, din, read, rd_adr, expected rd_dout, expected rd_fwrd.
  stim_t tbl [NUM_ROWS] = '{
    '{1'b1, 8'h10, 32'hffff_ffff, 32'h1111_1111, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b1, 8'h11, 32'hffff_ffff, 32'h2222_2222, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b1, 8'h14, 32'hffff_ffff, 32'h3333_4444, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b1, 8'h12, 32'hffff_ffff, 32'h7777_8888, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b1, 8'hfb, 32'hffff_ffff, 32'h9999_aaaa, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'h1111_1111, 1'b0},
    '{1'b1, 8'h10, 32'h0000_ffff, 32'haaaa_bbbb, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'h1111_bbbb, 1'b0},
    // Collision, then forwarded read, then flush on idle.
    '{1'b1, 8'h10, 32'hffff_ffff, 32'hcafe_0001, 1'b1, 8'h10, 32'h1111_bbbb, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'hcafe_0001, 1'b1},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'hcafe_0001, 1'b0},
    // Masked merges in the holding register, then eviction by a collision elsewhere.
    '{1'b1, 8'h10, 32'h0000_00ff, 32'h0000_0011, 1'b1, 8'h10, 32'hcafe_0001, 1'b0},
    '{1'b1, 8'h10, 32'h0000_ff00, 32'h0000_2200, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b1, 8'h10, 32'hff00_0000, 32'h4400_0000, 1'b1, 8'h11, 32'h2222_2222, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'h44fe_2211, 1'b1},
    '{1'b1, 8'h14, 32'hffff_ffff, 32'h5555_6666, 1'b1, 8'h14, 32'h3333_4444, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'h44fe_2211, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h14, 32'h5555_6666, 1'b1},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b0, 8'h00, 32'h0000_0000, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h14, 32'h5555_6666, 1'b0},
    // Back-to-back sweep over all four banks.
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h10, 32'h44fe_2211, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h11, 32'h2222_2222, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'h12, 32'h7777_8888, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1, 8'hfb, 32'h9999_aaaa, 1'b0},
    '{1'b0, 8'h00, 32'h0000_0000, 32'h0000_0000, 1'b0, 8'h00, 32'h0000_0000, 1'b0}
  };

  banked_mem_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .bw      (bw),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ============================================================
  // Helpers
  // ============================================================
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic mem_data_t merge_bits(mem_data_t old, mem_data_t nw, mem_mask_t msk);
    return (old & ~msk) | (nw & msk);
  endfunction

  // Bank bits sit above the row bits.
  function automatic phys_addr_t phys_of(log_addr_t a);
    return {a[`MEM_BANK_BITS-1:0], a[`MEM_ADDR_BITS-1:`MEM_BANK_BITS]};
  endfunction

  function automatic mem_data_t fill_word(int a);
    logic [7:0] b;
    b = a[7:0];
    return {~b, b ^ 8'h5a, b + 8'h33, b};
  endfunction

  function automatic stim_t random_stim();
    stim_t       s;
    logic [31:0] r;
    s = '0;
    r = take_bits(2);
    s.write = r[1];
    s.read  = r[0];
    // Narrow address range, half the reads aimed at the write address.
    r = take_bits(3);
    s.wr_adr = log_addr_t'(r[2:0]);
    r = take_bits(1);
    if (r[0]) begin
      s.rd_adr = s.wr_adr;
    end else begin
      r = take_bits(3);
      s.rd_adr = log_addr_t'(r[2:0]);
    end
    r = take_bits(1);
    if (r[0]) begin
      s.bw = '1;
    end else begin
      s.bw = take_bits(32);
    end
    s.din = take_bits(32);
    return s;
  endfunction

  task automatic model_cycle(input stim_t s, output mem_data_t exp_d, output logic exp_f);
    logic cflt;
    logic hit;
    cflt  = s.write && s.read && (s.wr_adr == s.rd_adr);
    hit   = held_on && (s.wr_adr == held_adr);
    exp_f = held_on && (s.rd_adr == held_adr);
    exp_d = model_mem[s.rd_adr];
    if (exp_f) begin
      exp_d = merge_bits(exp_d, held_dat, held_msk);
    end
    if (!s.write && !s.read) begin
      if (held_on) begin
        model_mem[held_adr] = merge_bits(model_mem[held_adr], held_dat, held_msk);
      end
      held_on = 1'b0;
    end else if (s.write && hit) begin
      held_dat = merge_bits(held_dat, s.din, s.bw);
      held_msk = held_msk | s.bw;
    end else if (cflt) begin
      if (held_on) begin
        model_mem[held_adr] = merge_bits(model_mem[held_adr], held_dat, held_msk);
      end
      held_on  = 1'b1;
      held_adr = s.wr_adr;
      held_msk = s.bw;
      held_dat = s.din;
    end else if (s.write) begin
      model_mem[s.wr_adr] = merge_bits(model_mem[s.wr_adr], s.din, s.bw);
    end
  endtask

  task automatic apply_cycle(input stim_t s, input logic from_table);
    mem_data_t m_d;
    logic      m_f;
    exp_t      e;
    @(posedge clk);
    write  <= s.write;
    wr_adr <= s.wr_adr;
    bw     <= s.bw;
    din    <= s.din;
    read   <= s.read;
    rd_adr <= s.rd_adr;
    model_cycle(s, m_d, m_f);
    if (s.read) begin
      e.dout = from_table ? s.exp_dout : m_d;
      e.fwd  = from_table ? s.exp_fwd : m_f;
      e.padr = phys_of(s.rd_adr);
      e.due  = cyc + 1 + DLY;
      exp_q.push_back(e);
    end
  endtask

  // ============================================================
  // Compare tasks
  // ============================================================
  task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
    end
  endtask

  task automatic check_padr(input string name, input phys_addr_t got, input phys_addr_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      val_errs++;
      $display("Fail %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
    end
  endtask

  // Results are sampled mid-cycle.
  always @(negedge clk) begin : monitor
    exp_t e;
    if (!rst) begin
      if (rd_vld) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("Read result at cycle %0d with no read pending", cyc);
        end else begin
          e = exp_q.pop_front();
          if (e.due != cyc) begin
            proto_errs++;
            $display("Read result came at cycle %0d instead of cycle %0d", cyc, e.due);
          end
          check_data("rd_dout", rd_dout, e.dout);
          check_flag("rd_fwrd", rd_fwrd, e.fwd);
          check_padr("rd_padr", rd_padr, e.padr);
          reads_seen++;
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
        proto_errs++;
        $display("No read result by cycle %0d for a read issued earlier", cyc);
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin : main
    stim_t s;
    int    n;
    rst    = 1'b1;
    write  = 1'b0;
    wr_adr = '0;
    bw     = '0;
    din    = '0;
    read   = 1'b0;
    rd_adr = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Quiet cycles after reset.
    s = '0;
    for (int i = 0; i < 4; i++) begin
      apply_cycle(s, 1'b0);
    end

    for (int a = 0; a < (1 << `MEM_ADDR_BITS); a++) begin
      s        = '0;
      s.write  = 1'b1;
      s.wr_adr = log_addr_t'(a);
      s.bw     = '1;
      s.din    = fill_word(a);
      apply_cycle(s, 1'b0);
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_cycle(tbl[i], 1'b1);
    end

    for (int i = 0; i < RAND_CYCLES; i++) begin
      apply_cycle(random_stim(), 1'b0);
    end

    n = 0;
    s = '0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      apply_cycle(s, 1'b0);
      n++;
    end
    if (exp_q.size() != 0) begin
      proto_errs++;
      $display("Timed out waiting for %0d read results", exp_q.size());
    end

    $display("Reads checked: %0d, value errors: %0d, other errors: %0d",
             reads_seen, val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hw
hw/mem_addr_pkg.sv
hw/mem_data_pkg.sv
hw/write_defer_ctrl.sv
hw/bank_sram.sv
hw/read_return.sv
hw/banked_mem_top.sv
verif/banked_mem_tb.sv

// ==== Makefile ====
SIM       := verilator
TOP       := banked_mem_tb
FLIST     := flist.f
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
